// ==== sat_lvl_macros.svh ====
// level-state store sizing
// slice count and field widths shared by package and RTL

`ifndef SAT_LVL_MACROS_SVH
`define SAT_LVL_MACROS_SVH

// one slice per decision level
`define SAT_NUM_LVLS 8

// level number carried with each command and stored per slice
`define SAT_WIDTH_LVL 16

`define SAT_WIDTH_BIN_ID 10

// bin in the upper bits, has-backtracked flag in bit 0
`define SAT_WIDTH_LVL_STATES (`SAT_WIDTH_BIN_ID + 1)

// log2 of the slice count
`define SAT_WIDTH_IDX 3

`endif

// ==== sat_lvl_pkg.sv ====
// level-state store types
// opcode enum plus bin, level, state word and slice index types

`include "sat_lvl_macros.svh"

package sat_lvl_pkg;

    // controller command set
    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_DECIDE = 3'd1,   // write bin for a level
        OP_LOAD   = 3'd2,   // restore packed state word
        OP_READ   = 3'd3,
        OP_BKT    = 3'd4    // search and apply backtrack
    } lvl_op_e;

    typedef logic [`SAT_WIDTH_BIN_ID-1:0] bin_id_t;
    typedef logic [`SAT_WIDTH_LVL-1:0]    lvl_t;

    // {bin, has_bkt}
    typedef logic [`SAT_WIDTH_LVL_STATES-1:0] lvl_states_t;

    typedef logic [`SAT_WIDTH_IDX-1:0] lvl_idx_t;

endpackage

// ==== lvl_state.sv ====
// single decision-level slice
// holds level, decided bin and has-backtracked flag, and forms one link of the find chain

`timescale 1ns/1ps

module lvl_state
    import sat_lvl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // decision write
    input  logic        valid_from_decision_i,
    input  bin_id_t     cur_bin_num_i,
    input  lvl_t        cur_lvl_i,

    // find chain, flag runs from the top slice downward
    input  logic [1:0]  findflag_i,
    output logic [1:0]  findflag_o,
    input  lvl_t        max_lvl_i,
    output bin_id_t     bkt_bin_o,
    output logic        findindex_o,

    input  logic        apply_bkt_i,

    // load and read of the packed word
    input  logic        wr_states_i,
    input  lvl_states_t lvl_states_i,
    output lvl_states_t lvl_states_o
);

    lvl_t    var_lvl;
    bin_id_t dcd_bin;
    logic    has_bkt;

    bin_id_t ld_bin;
    logic    ld_has_bkt;

    assign {ld_bin, ld_has_bkt} = lvl_states_i;
    assign lvl_states_o         = {dcd_bin, has_bkt};

    // 2 = found higher up, 1 = this slice, 0 = still searching
    always_comb begin
        if (findflag_i != 2'd0)
            findflag_o = 2'd2;
        else if (max_lvl_i >= var_lvl && !has_bkt)
            findflag_o = 2'd1;
        else
            findflag_o = 2'd0;
    end

    assign findindex_o = (findflag_o == 2'd1);

    // level follows both load and decision
    always_ff @(posedge clk) begin
        if (!rst)
            var_lvl <= '0;
        else if (wr_states_i || valid_from_decision_i)
            var_lvl <= cur_lvl_i;
    end

    always_ff @(posedge clk) begin
        if (!rst)
            dcd_bin <= '0;
        else if (wr_states_i)               // load wins over decide
            dcd_bin <= ld_bin;
        else if (valid_from_decision_i)
            dcd_bin <= cur_bin_num_i;
    end

    // above the hit clears, the hit flips to set, below keeps
    always_ff @(posedge clk) begin
        if (!rst) begin
            has_bkt <= 1'b0;
        end else if (wr_states_i) begin
            has_bkt <= ld_has_bkt;
        end else if (apply_bkt_i) begin
            case (findflag_o)
                2'd0:    has_bkt <= 1'b0;
                2'd1:    has_bkt <= 1'b1;
                default: has_bkt <= has_bkt;
            endcase
        end
    end

    // only the hit slice offers its bin, rest stay zero for the OR
    always_ff @(posedge clk) begin
        if (!rst)
            bkt_bin_o <= '0;
        else if (findindex_o)
            bkt_bin_o <= dcd_bin;
        else
            bkt_bin_o <= '0;
    end

endmodule

// ==== lvl_cmd_decode.sv ====
// command decode stage
// registers the command fields and turns the opcode into one strobe plus a slice select

`timescale 1ns/1ps

`include "sat_lvl_macros.svh"

module lvl_cmd_decode
    import sat_lvl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     cmd_valid_i,
    input  lvl_op_e                  cmd_op_i,
    input  lvl_t                     cmd_lvl_i,
    input  bin_id_t                  cmd_bin_i,
    input  lvl_states_t              cmd_states_i,
    input  lvl_t                     cmd_max_lvl_i,

    output logic [`SAT_NUM_LVLS-1:0] dec_sel_o,
    output logic                     dcd_wr_o,
    output logic                     ld_wr_o,
    output logic                     rd_o,
    output logic                     bkt_o,
    output lvl_t                     lvl_o,
    output bin_id_t                  bin_o,
    output lvl_states_t              states_o,
    output lvl_t                     max_lvl_o
);

    logic [`SAT_NUM_LVLS-1:0] sel_d;

    // slice picked by the low bits of the level
    always_comb begin
        sel_d = '0;
        sel_d[cmd_lvl_i[`SAT_WIDTH_IDX-1:0]] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dcd_wr_o  <= 1'b0;
            ld_wr_o   <= 1'b0;
            rd_o      <= 1'b0;
            bkt_o     <= 1'b0;
            dec_sel_o <= '0;
            max_lvl_o <= '0;    // feeds the find chain every cycle
        end else begin
            dcd_wr_o <= 1'b0;
            ld_wr_o  <= 1'b0;
            rd_o     <= 1'b0;
            bkt_o    <= 1'b0;
            if (cmd_valid_i) begin
                dec_sel_o <= sel_d;
                max_lvl_o <= cmd_max_lvl_i;
                case (cmd_op_i)
                    OP_DECIDE: dcd_wr_o <= 1'b1;
                    OP_LOAD:   ld_wr_o  <= 1'b1;
                    OP_READ:   rd_o     <= 1'b1;
                    OP_BKT:    bkt_o    <= 1'b1;
                    default:   ;    // nop
                endcase
            end
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            lvl_o    <= cmd_lvl_i;
            bin_o    <= cmd_bin_i;
            states_o <= cmd_states_i;
        end
    end

endmodule

// ==== lvl_stack.sv ====
// slice array of the level-state store
// chains find flags top-down and merges found index, bin and read word

`timescale 1ns/1ps

`include "sat_lvl_macros.svh"

module lvl_stack
    import sat_lvl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SAT_NUM_LVLS-1:0] sel_i,
    input  logic                     dcd_wr_i,
    input  logic                     ld_wr_i,
    input  logic                     bkt_i,
    input  lvl_t                     lvl_i,
    input  bin_id_t                  bin_i,
    input  lvl_states_t              states_i,
    input  lvl_t                     max_lvl_i,
    output logic                     find_hit_o,
    output lvl_idx_t                 find_idx_o,
    output bin_id_t                  stack_bin_o,
    output lvl_states_t              rd_word_o
);

    // flag_link[i+1] enters slice i, flag_link[i] leaves it
    logic [1:0]               flag_link [0:`SAT_NUM_LVLS];
    logic [`SAT_NUM_LVLS-1:0] hit_vec;
    bin_id_t                  slice_bin [`SAT_NUM_LVLS];
    lvl_states_t              slice_word [`SAT_NUM_LVLS];

    assign flag_link[`SAT_NUM_LVLS] = 2'd0;     // nothing above the top slice

    for (genvar g = 0; g < `SAT_NUM_LVLS; g++) begin : g_slice
        lvl_state u_slice (
            .clk                   (clk),
            .rst                   (rst),
            .valid_from_decision_i (dcd_wr_i & sel_i[g]),
            .cur_bin_num_i         (bin_i),
            .cur_lvl_i             (lvl_i),
            .findflag_i            (flag_link[g+1]),
            .findflag_o            (flag_link[g]),
            .max_lvl_i             (max_lvl_i),
            .bkt_bin_o             (slice_bin[g]),
            .findindex_o           (hit_vec[g]),
            .apply_bkt_i           (bkt_i),
            .wr_states_i           (ld_wr_i & sel_i[g]),
            .lvl_states_i          (states_i),
            .lvl_states_o          (slice_word[g])
        );
    end

    // bottom of the chain is nonzero once any slice matched
    assign find_hit_o = (flag_link[0] != 2'd0);

    always_comb begin
        find_idx_o  = '0;
        stack_bin_o = '0;
        rd_word_o   = '0;
        for (int i = 0; i < `SAT_NUM_LVLS; i++) begin
            if (hit_vec[i])
                find_idx_o = lvl_idx_t'(i);
            stack_bin_o = stack_bin_o | slice_bin[i];   // at most one nonzero
            if (sel_i[i])
                rd_word_o = rd_word_o | slice_word[i];
        end
    end

endmodule

// ==== lvl_result.sv ====
// result stage
// captures find and read data with their strobes, presents them one edge later

`timescale 1ns/1ps

module lvl_result
    import sat_lvl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        bkt_i,
    input  logic        rd_i,
    input  logic        find_hit_i,
    input  lvl_idx_t    find_idx_i,
    input  bin_id_t     stack_bin_i,
    input  lvl_states_t rd_word_i,
    output logic        bkt_valid_o,
    output logic        bkt_found_o,
    output lvl_idx_t    bkt_lvl_o,
    output bin_id_t     bkt_bin_o,
    output logic        rd_valid_o,
    output lvl_states_t rd_states_o
);

    logic        bkt_q;
    logic        rd_q;
    logic        found_q;
    lvl_idx_t    idx_q;
    lvl_states_t rd_word_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bkt_q       <= 1'b0;
            rd_q        <= 1'b0;
            bkt_valid_o <= 1'b0;
            rd_valid_o  <= 1'b0;
        end else begin
            bkt_q       <= bkt_i;
            rd_q        <= rd_i;
            bkt_valid_o <= bkt_q;   // single-cycle pulse
            rd_valid_o  <= rd_q;
        end
    end

    // first edge, same edge the slices apply the backtrack
    always_ff @(posedge clk) begin
        if (bkt_i) begin
            found_q <= find_hit_i;
            idx_q   <= find_idx_i;
        end
        if (rd_i)
            rd_word_q <= rd_word_i;
    end

    // second edge, slice bin registered one edge earlier
    always_ff @(posedge clk) begin
        if (bkt_q) begin
            bkt_found_o <= found_q;
            bkt_lvl_o   <= idx_q;
            bkt_bin_o   <= stack_bin_i;
        end
        if (rd_q)
            rd_states_o <= rd_word_q;
    end

endmodule

// ==== lvl_engine_top.sv ====
// level-state store top
// decode, slice stack and result stage of the backtracking unit

`timescale 1ns/1ps

`include "sat_lvl_macros.svh"

module lvl_engine_top
    import sat_lvl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid_i,
    input  lvl_op_e     cmd_op_i,
    input  lvl_t        cmd_lvl_i,
    input  bin_id_t     cmd_bin_i,
    input  lvl_states_t cmd_states_i,
    input  lvl_t        cmd_max_lvl_i,
    output logic        bkt_valid_o,
    output logic        bkt_found_o,
    output lvl_idx_t    bkt_lvl_o,
    output bin_id_t     bkt_bin_o,
    output logic        rd_valid_o,
    output lvl_states_t rd_states_o
);

    logic [`SAT_NUM_LVLS-1:0] dec_sel;
    logic                     dcd_wr;
    logic                     ld_wr;
    logic                     rd;
    logic                     bkt;
    lvl_t                     dec_lvl;
    bin_id_t                  dec_bin;
    lvl_states_t              dec_states;
    lvl_t                     dec_max_lvl;

    logic                     find_hit;
    lvl_idx_t                 find_idx;
    bin_id_t                  stack_bin;
    lvl_states_t              rd_word;

    lvl_cmd_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_op_i      (cmd_op_i),
        .cmd_lvl_i     (cmd_lvl_i),
        .cmd_bin_i     (cmd_bin_i),
        .cmd_states_i  (cmd_states_i),
        .cmd_max_lvl_i (cmd_max_lvl_i),
        .dec_sel_o     (dec_sel),
        .dcd_wr_o      (dcd_wr),
        .ld_wr_o       (ld_wr),
        .rd_o          (rd),
        .bkt_o         (bkt),
        .lvl_o         (dec_lvl),
        .bin_o         (dec_bin),
        .states_o      (dec_states),
        .max_lvl_o     (dec_max_lvl)
    );

    lvl_stack u_stack (
        .clk         (clk),
        .rst         (rst),
        .sel_i       (dec_sel),
        .dcd_wr_i    (dcd_wr),
        .ld_wr_i     (ld_wr),
        .bkt_i       (bkt),
        .lvl_i       (dec_lvl),
        .bin_i       (dec_bin),
        .states_i    (dec_states),
        .max_lvl_i   (dec_max_lvl),
        .find_hit_o  (find_hit),
        .find_idx_o  (find_idx),
        .stack_bin_o (stack_bin),
        .rd_word_o   (rd_word)
    );

    lvl_result u_result (
        .clk         (clk),
        .rst         (rst),
        .bkt_i       (bkt),
        .rd_i        (rd),
        .find_hit_i  (find_hit),
        .find_idx_i  (find_idx),
        .stack_bin_i (stack_bin),
        .rd_word_i   (rd_word),
        .bkt_valid_o (bkt_valid_o),
        .bkt_found_o (bkt_found_o),
        .bkt_lvl_o   (bkt_lvl_o),
        .bkt_bin_o   (bkt_bin_o),
        .rd_valid_o  (rd_valid_o),
        .rd_states_o (rd_states_o)
    );

endmodule

// ==== tb_clkgen.sv ====
// testbench clock and reset generator
// free-running clock, active-low reset held for the first few cycles

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on a rising edge, like the synchronous reset it feeds
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== tb_lvl_engine_asserts.sv ====
// protocol checks for the level-state store
// strobe exclusivity and slice select in decode, fixed command-to-result latency

`timescale 1ns/1ps

`include "sat_lvl_macros.svh"

module tb_lvl_engine_asserts
    import sat_lvl_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic                     cmd_valid_i,
    input lvl_op_e                  cmd_op_i,
    input logic                     dcd_wr_i,
    input logic                     ld_wr_i,
    input logic                     rd_i,
    input logic                     bkt_i,
    input logic [`SAT_NUM_LVLS-1:0] sel_i,
    input logic                     rd_valid_i,
    input logic                     bkt_valid_i
);

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({dcd_wr_i, ld_wr_i, rd_i, bkt_i}))
        else $error("more than one decode strobe high");

    // a write must land in exactly one slice
    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst)
        (dcd_wr_i || ld_wr_i) |-> $onehot(sel_i))
        else $error("slice select not one-hot during a write");

    // command sampled at E0, valid seen at the edge after E2
    a_bkt_latency: assert property (@(posedge clk) disable iff (!rst)
        bkt_valid_i == $past(cmd_valid_i && cmd_op_i == OP_BKT, 3))
        else $error("backtrack valid not two cycles after its command");

    a_rd_latency: assert property (@(posedge clk) disable iff (!rst)
        rd_valid_i == $past(cmd_valid_i && cmd_op_i == OP_READ, 3))
        else $error("read valid not two cycles after its command");

endmodule

// decode strobes and result valids meet at the top level
bind lvl_engine_top tb_lvl_engine_asserts u_chk (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .dcd_wr_i    (dcd_wr),
    .ld_wr_i     (ld_wr),
    .rd_i        (rd),
    .bkt_i       (bkt),
    .sel_i       (dec_sel),
    .rd_valid_i  (rd_valid_o),
    .bkt_valid_i (bkt_valid_o)
);

// ==== tb_lvl_engine.sv ====
// testbench for the level-state store
// reference model of the slice array, LFSR stimulus and in-order result checks

`timescale 1ns/1ps

`include "sat_lvl_macros.svh"

module tb_lvl_engine
    import sat_lvl_pkg::*;
();

    localparam int BKT_ROUNDS  = 6;
    localparam int MIX_CMDS    = 200;
    localparam int NUM_CMDS    = 9 + 16 + 16 + BKT_ROUNDS * 9 + MIX_CMDS;
    localparam int WATCHDOG_NS = NUM_CMDS * 40 + 2000;

    typedef struct packed {
        logic        is_bkt;
        logic        found;
        lvl_idx_t    idx;
        bin_id_t     bin;
        lvl_states_t word;
        logic [31:0] due;       // edge count at which the result is seen
    } exp_t;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    lvl_op_e     cmd_op;
    lvl_t        cmd_lvl;
    bin_id_t     cmd_bin;
    lvl_states_t cmd_states;
    lvl_t        cmd_max_lvl;
    logic        bkt_valid;
    logic        bkt_found;
    lvl_idx_t    bkt_lvl;
    bin_id_t     bkt_bin;
    logic        rd_valid;
    lvl_states_t rd_states;

    // model of the slice array
    lvl_t        m_lvl [`SAT_NUM_LVLS];
    bin_id_t     m_bin [`SAT_NUM_LVLS];
    logic        m_bkt [`SAT_NUM_LVLS];

    exp_t        exp_q [$];
    int          edge_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;
    logic [15:0] lfsr;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    lvl_engine_top uut (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid_i   (cmd_valid),
        .cmd_op_i      (cmd_op),
        .cmd_lvl_i     (cmd_lvl),
        .cmd_bin_i     (cmd_bin),
        .cmd_states_i  (cmd_states),
        .cmd_max_lvl_i (cmd_max_lvl),
        .bkt_valid_o   (bkt_valid),
        .bkt_found_o   (bkt_found),
        .bkt_lvl_o     (bkt_lvl),
        .bkt_bin_o     (bkt_bin),
        .rd_valid_o    (rd_valid),
        .rd_states_o   (rd_states)
    );

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 16'hB400;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // applies one command to the model and returns what it should produce
    function automatic exp_t ref_model(input lvl_op_e op, input lvl_t lvl, input bin_id_t bin,
                                       input lvl_states_t states, input lvl_t max_lvl);
        exp_t     e;
        lvl_idx_t s;
        int       i;
        e = '0;
        s = lvl[`SAT_WIDTH_IDX-1:0];
        case (op)
            OP_DECIDE: begin
                m_lvl[s] = lvl;
                m_bin[s] = bin;
            end
            OP_LOAD: begin
                m_lvl[s] = lvl;
                {m_bin[s], m_bkt[s]} = states;
            end
            OP_READ: e.word = {m_bin[s], m_bkt[s]};
            OP_BKT: begin
                e.is_bkt = 1'b1;
                for (i = `SAT_NUM_LVLS - 1; i >= 0; i--) begin   // top slice first
                    if (!e.found && max_lvl >= m_lvl[i] && !m_bkt[i]) begin
                        e.found = 1'b1;
                        e.idx   = lvl_idx_t'(i);
                        e.bin   = m_bin[i];
                    end
                end
                for (i = 0; i < `SAT_NUM_LVLS; i++) begin
                    if (e.found && lvl_idx_t'(i) == e.idx)
                        m_bkt[i] = 1'b1;
                    else if (!e.found || lvl_idx_t'(i) > e.idx)
                        m_bkt[i] = 1'b0;    // below the hit keeps its flag
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic issue(input lvl_op_e op, input lvl_t lvl, input bin_id_t bin,
                         input lvl_states_t states, input lvl_t max_lvl);
        exp_t e;
        @(posedge clk);
        cmd_valid   <= 1'b1;
        cmd_op      <= op;
        cmd_lvl     <= lvl;
        cmd_bin     <= bin;
        cmd_states  <= states;
        cmd_max_lvl <= max_lvl;
        e     = ref_model(op, lvl, bin, states, max_lvl);
        e.due = 32'(edge_cnt + 4);  // sampled next edge, out two edges later
        if (op == OP_READ || op == OP_BKT)
            exp_q.push_back(e);
    endtask

    task automatic drain();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_op    <= OP_NOP;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int chk0, input int err0);
        $display("%-12s checks %0d, errors %0d", name, check_cnt - chk0, err_cnt - err0);
    endtask

    task automatic check_bkt(input logic found_exp, input lvl_idx_t lvl_exp,
                             input bin_id_t bin_exp);
        check_cnt++;
        if (bkt_found !== found_exp) begin
            $display("FAILED at %0t ns: backtrack found %0b, expected %0b",
                     $time, bkt_found, found_exp);
            err_cnt++;
        end else if (found_exp && (bkt_lvl !== lvl_exp || bkt_bin !== bin_exp)) begin
            $display({"FAILED at %0t ns: backtrack level %0d bin 0x%0h,",
                      " expected level %0d bin 0x%0h"},
                     $time, bkt_lvl, bkt_bin, lvl_exp, bin_exp);
            err_cnt++;
        end
    endtask

    task automatic check_rd(input lvl_states_t word_exp);
        check_cnt++;
        if (rd_states !== word_exp) begin
            $display("FAILED at %0t ns: read word 0x%0h, expected 0x%0h",
                     $time, rd_states, word_exp);
            err_cnt++;
        end
    endtask

    task automatic compare_next(input logic is_bkt);
        exp_t  e;
        string kind;
        kind = is_bkt ? "backtrack" : "read";
        if (exp_q.size() == 0) begin
            $display("error at %0t ns: %s result came out with nothing expected", $time, kind);
            err_cnt++;
        end else begin
            e = exp_q.pop_front();
            if (e.is_bkt != is_bkt || e.due != 32'(edge_cnt)) begin
                $display({"error at %0t ns: %s result out of order",
                          " or not two cycles after its command"}, $time, kind);
                err_cnt++;
            end else if (is_bkt) begin
                check_bkt(e.found, e.idx, e.bin);
            end else begin
                check_rd(e.word);
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst === 1'b1) begin
            if (bkt_valid)
                compare_next(1'b1);
            if (rd_valid)
                compare_next(1'b0);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          i;
        int          chk0;
        int          err0;
        logic [1:0]  pick;
        lvl_op_e     op;
        lvl_t        lvl;
        bin_id_t     bin;
        lvl_states_t st;
        lvl_t        mx;
        cmd_valid   = 1'b0;
        cmd_op      = OP_NOP;
        cmd_lvl     = '0;
        cmd_bin     = '0;
        cmd_states  = '0;
        cmd_max_lvl = '0;
        lfsr        = 16'd13144;
        for (i = 0; i < `SAT_NUM_LVLS; i++) begin
            m_lvl[i] = '0;
            m_bin[i] = '0;
            m_bkt[i] = 1'b0;
        end
        while (rst !== 1'b1)
            @(posedge clk);

        chk0 = check_cnt;
        err0 = err_cnt;
        for (i = 0; i < `SAT_NUM_LVLS; i++)
            issue(OP_READ, lvl_t'(i), '0, '0, '0);
        issue(OP_BKT, '0, '0, '0, lvl_t'(rand_bits(16)));
        drain();
        end_test("reset", chk0, err0);

        chk0 = check_cnt;
        err0 = err_cnt;
        for (i = 0; i < `SAT_NUM_LVLS; i++)
            issue(OP_DECIDE, lvl_t'(i), bin_id_t'(rand_bits(10)), '0, '0);
        for (i = 0; i < `SAT_NUM_LVLS; i++)
            issue(OP_READ, lvl_t'(i), '0, '0, '0);
        drain();
        end_test("decide", chk0, err0);

        chk0 = check_cnt;
        err0 = err_cnt;
        for (i = 0; i < `SAT_NUM_LVLS; i++) begin
            lvl = lvl_t'(rand_bits(3));
            st  = lvl_states_t'(rand_bits(11));
            issue(OP_LOAD, lvl, '0, st, '0);
        end
        for (i = 0; i < `SAT_NUM_LVLS; i++)
            issue(OP_READ, lvl_t'(i), '0, '0, '0);
        drain();
        end_test("load", chk0, err0);

        chk0 = check_cnt;
        err0 = err_cnt;
        repeat (BKT_ROUNDS) begin
            issue(OP_BKT, '0, '0, '0, lvl_t'(rand_bits(4)));
            for (i = 0; i < `SAT_NUM_LVLS; i++)     // flags above, at and below the hit
                issue(OP_READ, lvl_t'(i), '0, '0, '0);
        end
        drain();
        end_test("backtrack", chk0, err0);

        chk0 = check_cnt;
        err0 = err_cnt;
        repeat (MIX_CMDS) begin
            pick = 2'(rand_bits(2));
            lvl  = lvl_t'(rand_bits(3));
            bin  = bin_id_t'(rand_bits(10));
            st   = lvl_states_t'(rand_bits(11));
            mx   = lvl_t'(rand_bits(4));
            case (pick)
                2'd0:    op = OP_DECIDE;
                2'd1:    op = OP_LOAD;
                2'd2:    op = OP_READ;
                default: op = OP_BKT;
            endcase
            issue(op, lvl, bin, st, mx);
        end
        drain();
        end_test("mixed", chk0, err0);

        $display("total checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
sat_lvl_pkg.sv
lvl_state.sv
lvl_cmd_decode.sv
lvl_stack.sv
lvl_result.sv
lvl_engine_top.sv
tb_clkgen.sv
tb_lvl_engine_asserts.sv
tb_lvl_engine.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_lvl_engine \
    -f flist.f -o sim_lvl_engine \
    && ./obj_dir/sim_lvl_engine | tee /dev/stderr | grep -q "Verification passed" \
    && echo "run: simulation ok" \
    || { echo "run: simulation reported a failure"; exit 1; }
